// ==== dv/mul_unit_tb.sv ====
`default_nettype none

module mul_unit_tb;

    import mul_pkg::*;

    logic                clk_i;
    logic                rst_i;
    logic                op_valid_i;
    logic [FUNCT3_W-1:0] funct3_i;
    logic [XLEN-1:0]     rs1_i;
    logic [XLEN-1:0]     rs2_i;
    logic                result_valid_o;
    logic [XLEN-1:0]     result_o;

    // expected words and issue cycles in issue order
    logic [XLEN-1:0] exp_q[$];
    int              cyc_q[$];

    integer seed;
    int     cycle_cnt;
    int     errors;
    int     checks;
    int     tests;
    int     issued;
    int     results_seen;
    int     test_err0;
    int     test_iss0;
    int     test_res0;

    mul_unit mul_unit_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_valid_i     (op_valid_i),
        .funct3_i       (funct3_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // extend each operand per funct3 and take one half of the 64-bit product
    function automatic logic [XLEN-1:0] expected_result(input logic [FUNCT3_W-1:0] f3,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ext_a;
        logic [2*XLEN-1:0] ext_b;
        logic [2*XLEN-1:0] prod;
        if (f3 == F3_MULH || f3 == F3_MULHSU) begin
            ext_a = {{XLEN{a[XLEN-1]}}, a};
        end else begin
            ext_a = {{XLEN{1'b0}}, a};
        end
        if (f3 == F3_MULH) begin
            ext_b = {{XLEN{b[XLEN-1]}}, b};
        end else begin
            ext_b = {{XLEN{1'b0}}, b};
        end
        prod = ext_a * ext_b;
        return (f3 == F3_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    // compare each result against the oldest outstanding operation
    always @(negedge clk_i) begin
        logic [XLEN-1:0] exp_val;
        int              issue_cyc;
        if (rst_i === 1'b1 && result_valid_o === 1'b1) begin
            results_seen++;
            assert (exp_q.size() != 0) else begin
                $display("unexpected result %h at time %0t with no operation outstanding",
                         result_o, $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_val   = exp_q.pop_front();
                issue_cyc = cyc_q.pop_front();
                checks++;
                assert (result_o === exp_val) else begin
                    $display("FAIL time %0t result_o expected %h actual %h",
                             $time, exp_val, result_o);
                    errors++;
                end
                assert (cycle_cnt - issue_cyc == 3) else begin
                    $display("result at time %0t came %0d cycles after issue instead of 3",
                             $time, cycle_cnt - issue_cyc);
                    errors++;
                end
            end
        end
    end

    task automatic issue_op(input logic [FUNCT3_W-1:0] f3,
                            input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        @(negedge clk_i);
        op_valid_i = 1'b1;
        funct3_i   = f3;
        rs1_i      = a;
        rs2_i      = b;
        // latency counts from the cycle the operation is driven in
        exp_q.push_back(expected_result(f3, a, b));
        cyc_q.push_back(cycle_cnt);
        issued++;
    endtask

    task automatic idle_cycle();
        @(negedge clk_i);
        op_valid_i = 1'b0;
    endtask

    task automatic drain_results(input string name);
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk_i);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("test %s: %0d results did not arrive within 20 cycles",
                     name, exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
            cyc_q.delete();
        end
        // a few quiet cycles to catch stray results
        repeat (4) idle_cycle();
    endtask

    task automatic begin_test();
        test_err0 = errors;
        test_iss0 = issued;
        test_res0 = results_seen;
    endtask

    task automatic end_test(input string name);
        drain_results(name);
        assert (results_seen - test_res0 == issued - test_iss0) else begin
            $display("test %s: got %0d results for %0d operations",
                     name, results_seen - test_res0, issued - test_iss0);
            errors++;
        end
        tests++;
        if (errors == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err0);
        end
    endtask

    initial begin
        logic [31:0]         r;
        logic [FUNCT3_W-1:0] f3;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
        int                  stream_n;

        seed         = 82378;
        cycle_cnt    = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        issued       = 0;
        results_seen = 0;
        rst_i        = 1'b0;
        op_valid_i   = 1'b0;
        funct3_i     = '0;
        rs1_i        = '0;
        rs2_i        = '0;

        begin_test();
        repeat (10) begin
            @(negedge clk_i);
            assert (result_valid_o === 1'b0) else begin
                $display("result_valid_o was not low during reset at time %0t", $time);
                errors++;
            end
        end
        rst_i = 1'b1;
        repeat (5) begin
            @(negedge clk_i);
            assert (result_valid_o === 1'b0) else begin
                $display("result_valid_o rose while idle after reset at time %0t", $time);
                errors++;
            end
        end
        end_test("reset");

        begin_test();
        issue_op(F3_MUL, 32'd3, 32'd7);
        issue_op(F3_MUL, 32'd0, 32'h1234_5678);
        issue_op(F3_MUL, 32'hFFFF_FFFF, 32'd2);
        issue_op(F3_MUL, 32'h8000_0000, 32'h8000_0000);
        issue_op(F3_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(F3_MUL, 32'h8000_0001, 32'd3);
        end_test("mul_low");

        begin_test();
        issue_op(F3_MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(F3_MULHU, 32'd1, 32'h8000_0000);
        issue_op(F3_MULHU, 32'h8000_0000, 32'd2);
        issue_op(F3_MULHU, 32'hFFFF_FFFF, 32'd1);
        end_test("mulhu");

        begin_test();
        issue_op(F3_MULH, 32'h8000_0000, 32'h8000_0000);
        issue_op(F3_MULH, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(F3_MULH, 32'h8000_0000, 32'd1);
        issue_op(F3_MULH, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
        issue_op(F3_MULH, 32'hFFFF_FFFF, 32'd1);
        end_test("mulh");

        begin_test();
        issue_op(F3_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(F3_MULHSU, 32'h8000_0000, 32'hFFFF_FFFF);
        issue_op(F3_MULHSU, 32'd3, 32'h8000_0000);
        issue_op(F3_MULHSU, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
        end_test("mulhsu");

        // mostly back-to-back with random bubbles
        begin_test();
        stream_n = 0;
        while (stream_n < 300) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                idle_cycle();
            end else begin
                f3 = {1'b0, r[5:4]};
                a  = $random(seed);
                b  = $random(seed);
                issue_op(f3, a, b);
                stream_n++;
            end
        end
        end_test("stream");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --assert -Wno-fatal \
    --top-module mul_unit_tb \
    -f verilog.f \
    -o mul_unit_sim

./obj_dir/mul_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== verilog.f ====
verilog/mul_pkg.sv
verilog/vedic_mul.sv
verilog/mul_decode.sv
verilog/mul_execute.sv
verilog/mul_result.sv
verilog/mul_unit.sv
dv/mul_unit_tb.sv

// ==== verilog/mul_decode.sv ====
`default_nettype none

module mul_decode (
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          op_valid_i,
    input  wire logic [mul_pkg::FUNCT3_W-1:0]  funct3_i,
    input  wire logic [mul_pkg::XLEN-1:0]      rs1_i,
    input  wire logic [mul_pkg::XLEN-1:0]      rs2_i,
    output logic                               valid_o,
    output logic      [mul_pkg::XLEN-1:0]      mag1_o,
    output logic      [mul_pkg::XLEN-1:0]      mag2_o,
    output logic                               negate_o,
    output logic                               sel_high_o
);

    import mul_pkg::*;

    logic            rs1_signed;
    logic            rs2_signed;
    logic            sel_high;
    logic            rs1_neg;
    logic            rs2_neg;
    logic [XLEN-1:0] mag1;
    logic [XLEN-1:0] mag2;

    // operand signedness per funct3
    always_comb begin
        case (funct3_i)
            F3_MUL: begin
                rs1_signed = 1'b0;
                rs2_signed = 1'b0;
                sel_high   = 1'b0;
            end
            F3_MULH: begin
                rs1_signed = 1'b1;
                rs2_signed = 1'b1;
                sel_high   = 1'b1;
            end
            F3_MULHSU: begin
                rs1_signed = 1'b1;
                rs2_signed = 1'b0;
                sel_high   = 1'b1;
            end
            F3_MULHU: begin
                rs1_signed = 1'b0;
                rs2_signed = 1'b0;
                sel_high   = 1'b1;
            end
            default: begin
                rs1_signed = 1'b0;
                rs2_signed = 1'b0;
                sel_high   = 1'b1;
            end
        endcase
    end

    assign rs1_neg = rs1_signed & rs1_i[XLEN-1];
    assign rs2_neg = rs2_signed & rs2_i[XLEN-1];

    // two's-complement magnitude where -2^31 maps to 2^31 unsigned
    assign mag1 = rs1_neg ? (~rs1_i + 1'b1) : rs1_i;
    assign mag2 = rs2_neg ? (~rs2_i + 1'b1) : rs2_i;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_o    <= 1'b0;
            mag1_o     <= '0;
            mag2_o     <= '0;
            negate_o   <= 1'b0;
            sel_high_o <= 1'b0;
        end else begin
            valid_o <= op_valid_i;
            // hold data through bubbles
            if (op_valid_i) begin
                mag1_o     <= mag1;
                mag2_o     <= mag2;
                negate_o   <= rs1_neg ^ rs2_neg;
                sel_high_o <= sel_high;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mul_execute.sv ====
`default_nettype none

module mul_execute (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        valid_i,
    input  wire logic [mul_pkg::XLEN-1:0]    mag1_i,
    input  wire logic [mul_pkg::XLEN-1:0]    mag2_i,
    input  wire logic                        negate_i,
    input  wire logic                        sel_high_i,
    output logic                             valid_o,
    output logic      [mul_pkg::PROD_W-1:0]  product_o,
    output logic                             negate_o,
    output logic                             sel_high_o
);

    import mul_pkg::*;

    logic [XLEN-1:0]          pp_ll;
    logic [XLEN-1:0]          pp_hl;
    logic [XLEN-1:0]          pp_lh;
    logic [XLEN-1:0]          pp_hh;
    logic [XLEN-1:0]          sum_lo;
    logic [PROD_W-HALF_W-1:0] sum_cross;
    logic [PROD_W-HALF_W-1:0] sum_all;

    vedic_mul #(.WIDTH(HALF_W)) u_vedic_ll (
        .a_i (mag1_i[HALF_W-1:0]),
        .b_i (mag2_i[HALF_W-1:0]),
        .p_o (pp_ll)
    );

    vedic_mul #(.WIDTH(HALF_W)) u_vedic_hl (
        .a_i (mag1_i[XLEN-1:HALF_W]),
        .b_i (mag2_i[HALF_W-1:0]),
        .p_o (pp_hl)
    );

    vedic_mul #(.WIDTH(HALF_W)) u_vedic_lh (
        .a_i (mag1_i[HALF_W-1:0]),
        .b_i (mag2_i[XLEN-1:HALF_W]),
        .p_o (pp_lh)
    );

    vedic_mul #(.WIDTH(HALF_W)) u_vedic_hh (
        .a_i (mag1_i[XLEN-1:HALF_W]),
        .b_i (mag2_i[XLEN-1:HALF_W]),
        .p_o (pp_hh)
    );

    // first adder level
    assign sum_lo    = pp_hl + {{HALF_W{1'b0}}, pp_ll[XLEN-1:HALF_W]};
    assign sum_cross = {{HALF_W{1'b0}}, pp_lh} + {pp_hh, {HALF_W{1'b0}}};

    // 48-bit second adder level
    assign sum_all = {{HALF_W{1'b0}}, sum_lo} + sum_cross;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_o    <= 1'b0;
            product_o  <= '0;
            negate_o   <= 1'b0;
            sel_high_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                product_o  <= {sum_all, pp_ll[HALF_W-1:0]};
                negate_o   <= negate_i;
                sel_high_o <= sel_high_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

    // operand and result width
    localparam int XLEN = 32;

    // operand half fed to each vedic block
    localparam int HALF_W = XLEN / 2;

    // full product width
    localparam int PROD_W = 2 * XLEN;

    // funct3 field of the M extension
    localparam int FUNCT3_W = 3;

    // low word with both operands unsigned
    localparam logic [FUNCT3_W-1:0] F3_MUL = 3'd0;

    // high word of signed x signed
    localparam logic [FUNCT3_W-1:0] F3_MULH = 3'd1;

    // high word of signed rs1 x unsigned rs2
    localparam logic [FUNCT3_W-1:0] F3_MULHSU = 3'd2;

    // high word of unsigned x unsigned
    localparam logic [FUNCT3_W-1:0] F3_MULHU = 3'd3;

endpackage

`default_nettype wire

// ==== verilog/mul_result.sv ====
`default_nettype none

module mul_result (
    input  wire logic                        clk_i,
    input  wire logic                        rst_i,
    input  wire logic                        valid_i,
    input  wire logic [mul_pkg::PROD_W-1:0]  product_i,
    input  wire logic                        negate_i,
    input  wire logic                        sel_high_i,
    output logic                             result_valid_o,
    output logic      [mul_pkg::XLEN-1:0]    result_o
);

    import mul_pkg::*;

    logic [PROD_W-1:0] signed_prod;
    logic [XLEN-1:0]   word;

    // restore the sign on the full 64 bits so the high word borrows correctly
    assign signed_prod = negate_i ? (~product_i + 1'b1) : product_i;

    assign word = sel_high_i ? signed_prod[PROD_W-1:XLEN] : signed_prod[XLEN-1:0];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
        end else begin
            result_valid_o <= valid_i;
            if (valid_i) begin
                result_o <= word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mul_unit.sv ====
`default_nettype none

module mul_unit (
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          op_valid_i,
    input  wire logic [mul_pkg::FUNCT3_W-1:0]  funct3_i,
    input  wire logic [mul_pkg::XLEN-1:0]      rs1_i,
    input  wire logic [mul_pkg::XLEN-1:0]      rs2_i,
    output logic                               result_valid_o,
    output logic      [mul_pkg::XLEN-1:0]      result_o
);

    import mul_pkg::*;

    // decode to execute
    logic              dec_valid;
    logic [XLEN-1:0]   mag1;
    logic [XLEN-1:0]   mag2;
    logic              dec_negate;
    logic              dec_sel_high;

    // execute to result
    logic              ex_valid;
    logic [PROD_W-1:0] product;
    logic              ex_negate;
    logic              ex_sel_high;

    mul_decode u_decode (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .op_valid_i (op_valid_i),
        .funct3_i   (funct3_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .valid_o    (dec_valid),
        .mag1_o     (mag1),
        .mag2_o     (mag2),
        .negate_o   (dec_negate),
        .sel_high_o (dec_sel_high)
    );

    mul_execute u_execute (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (dec_valid),
        .mag1_i     (mag1),
        .mag2_i     (mag2),
        .negate_i   (dec_negate),
        .sel_high_i (dec_sel_high),
        .valid_o    (ex_valid),
        .product_o  (product),
        .negate_o   (ex_negate),
        .sel_high_o (ex_sel_high)
    );

    mul_result u_result (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (ex_valid),
        .product_i      (product),
        .negate_i       (ex_negate),
        .sel_high_i     (ex_sel_high),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

// ==== verilog/vedic_mul.sv ====
`default_nettype none

module vedic_mul #(
    parameter int WIDTH = 16
) (
    input  wire logic [WIDTH-1:0]   a_i,
    input  wire logic [WIDTH-1:0]   b_i,
    output logic      [2*WIDTH-1:0] p_o
);

    if (WIDTH == 2) begin : g_leaf
        logic [2:0] pp;
        logic       c1;

        // bit products
        assign pp[0] = a_i[1] & b_i[0];
        assign pp[1] = a_i[0] & b_i[1];
        assign pp[2] = a_i[1] & b_i[1];

        assign p_o[0] = a_i[0] & b_i[0];

        // first half adder on the cross terms
        assign p_o[1] = pp[0] ^ pp[1];
        assign c1     = pp[0] & pp[1];

        // second half adder folds the carry into the top term
        assign p_o[2] = pp[2] ^ c1;
        assign p_o[3] = pp[2] & c1;
    end else begin : g_tree
        logic [WIDTH-1:0]         q0;
        logic [WIDTH-1:0]         q1;
        logic [WIDTH-1:0]         q2;
        logic [WIDTH-1:0]         q3;
        logic [WIDTH-1:0]         sum_lo;
        logic [WIDTH+WIDTH/2-1:0] sum_cross;
        logic [WIDTH+WIDTH/2-1:0] sum_all;

        // four half-width products
        vedic_mul #(.WIDTH(WIDTH/2)) u_ll (
            .a_i (a_i[WIDTH/2-1:0]),
            .b_i (b_i[WIDTH/2-1:0]),
            .p_o (q0)
        );

        vedic_mul #(.WIDTH(WIDTH/2)) u_hl (
            .a_i (a_i[WIDTH-1:WIDTH/2]),
            .b_i (b_i[WIDTH/2-1:0]),
            .p_o (q1)
        );

        vedic_mul #(.WIDTH(WIDTH/2)) u_lh (
            .a_i (a_i[WIDTH/2-1:0]),
            .b_i (b_i[WIDTH-1:WIDTH/2]),
            .p_o (q2)
        );

        vedic_mul #(.WIDTH(WIDTH/2)) u_hh (
            .a_i (a_i[WIDTH-1:WIDTH/2]),
            .b_i (b_i[WIDTH-1:WIDTH/2]),
            .p_o (q3)
        );

        // stage 1
        assign sum_lo    = q1 + {{(WIDTH/2){1'b0}}, q0[WIDTH-1:WIDTH/2]};
        assign sum_cross = {{(WIDTH/2){1'b0}}, q2} + {q3, {(WIDTH/2){1'b0}}};

        // stage 2
        assign sum_all = {{(WIDTH/2){1'b0}}, sum_lo} + sum_cross;

        // low quarter passes straight through
        assign p_o = {sum_all, q0[WIDTH/2-1:0]};
    end

endmodule

`default_nettype wire
